/* design/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine CSR addresses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82

// Cause codes. Interrupt codes double as mie/mip bit positions.
`define CAUSE_ILLEGAL_INSTR 4'd2
`define IRQ_MSOFT           4'd3
`define IRQ_MTIMER          4'd7
`define IRQ_MEXT            4'd11

`define MISA_VALUE 32'h4000_1100 // MXL=1, I and M.

// mstatus field positions.
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP  12:11
`define MSTATUS_FS   14:13
`define MSTATUS_SD   31

// funct3 of the SYSTEM opcode.
`define F3_CSRRW  3'b001
`define F3_CSRRS  3'b010
`define F3_CSRRC  3'b011
`define F3_CSRRWI 3'b101
`define F3_CSRRSI 3'b110
`define F3_CSRRCI 3'b111

`endif

/* design/csr_pkg.sv */
package csr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths with a meaning.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Data word of the RV32 core.
  typedef logic [31:0] word_t;

  // CSR address field of the instruction.
  typedef logic [11:0] csr_addr_t;

  // Exception or interrupt code. The interrupt flag is kept apart.
  typedef logic [3:0] cause_t;

  // Register index, also the 5-bit immediate of the i-forms.
  typedef logic [4:0] reg_idx_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operation decoded from funct3.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_SET   = 2'd2,
    OP_CLEAR = 2'd3
  } csr_op_e;

endpackage

/* design/csr_decode.sv */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               instr_valid,
  input  logic [2:0]         instr_funct3,
  input  csr_pkg::csr_addr_t instr_addr,
  input  csr_pkg::reg_idx_t  instr_rs1,
  input  csr_pkg::word_t     instr_src,
  input  csr_pkg::reg_idx_t  instr_rd,
  input  csr_pkg::word_t     instr_pc,
  input  logic               exc_valid,
  input  csr_pkg::cause_t    exc_cause,
  input  csr_pkg::word_t     exc_pc,
  input  csr_pkg::word_t     exc_tval,
  input  logic               mret,
  input  logic               retire,
  output logic               s1_valid,
  output csr_pkg::csr_op_e   s1_op,
  output csr_pkg::csr_addr_t s1_addr,
  output csr_pkg::word_t     s1_operand,
  output csr_pkg::reg_idx_t  s1_rd,
  output csr_pkg::word_t     s1_pc,
  output logic               s1_exc,
  output csr_pkg::cause_t    s1_cause,
  output csr_pkg::word_t     s1_epc,
  output csr_pkg::word_t     s1_tval,
  output logic               s1_mret,
  output logic               s1_retire,
  output logic               s1_zero_src
);
  csr_pkg::csr_op_e op;
  csr_pkg::word_t   operand;
  logic             zero_src;
  logic             known;
  logic             illegal;

  always_comb begin
    case (instr_funct3)
      `F3_CSRRW, `F3_CSRRWI: op = csr_pkg::OP_WRITE;
      `F3_CSRRS, `F3_CSRRSI: op = csr_pkg::OP_SET;
      `F3_CSRRC, `F3_CSRRCI: op = csr_pkg::OP_CLEAR;
      default:               op = csr_pkg::OP_NONE;
    endcase

    case (instr_addr)
      `CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
      `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP,
      `CSR_MCYCLE, `CSR_MCYCLEH, `CSR_MINSTRET, `CSR_MINSTRETH: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  assign operand  = instr_funct3[2] ? {27'b0, instr_rs1} : instr_src; // Immediate forms.
  assign zero_src = (instr_rs1 == '0);

  // misa is read-only, so only a real write to it traps.
  assign illegal = !known || (instr_addr == `CSR_MISA &&
                   (op == csr_pkg::OP_WRITE || !zero_src));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage one registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst) begin
      s1_valid  <= 1'b0;
      s1_exc    <= 1'b0;
      s1_mret   <= 1'b0;
      s1_retire <= 1'b0;
    end else begin
      s1_valid  <= instr_valid && !illegal && op != csr_pkg::OP_NONE;
      s1_exc    <= exc_valid || (instr_valid && illegal);
      s1_mret   <= mret;
      s1_retire <= retire;
    end
  end

  always_ff @(posedge clk) begin
    s1_op       <= op;
    s1_addr     <= instr_addr;
    s1_operand  <= operand;
    s1_rd       <= instr_rd;
    s1_pc       <= instr_pc;
    s1_zero_src <= zero_src;
    s1_cause    <= exc_valid ? exc_cause : `CAUSE_ILLEGAL_INSTR;
    s1_epc      <= exc_valid ? exc_pc : instr_pc;
    s1_tval     <= exc_valid ? exc_tval : '0; // Illegal CSR access leaves tval zero.
  end

endmodule

/* design/csr_modify.sv */
`timescale 1ns/10ps

module csr_modify (
  input  logic               clk,
  input  logic               rst,
  input  logic               s1_valid,
  input  csr_pkg::csr_op_e   s1_op,
  input  csr_pkg::csr_addr_t s1_addr,
  input  csr_pkg::word_t     s1_operand,
  input  csr_pkg::reg_idx_t  s1_rd,
  input  logic               s1_zero_src,
  input  csr_pkg::word_t     rdata,
  output logic               wr_en,
  output csr_pkg::csr_addr_t wr_addr,
  output csr_pkg::word_t     wr_data,
  output logic               rd_valid,
  output csr_pkg::reg_idx_t  rd_index,
  output csr_pkg::word_t     rd_data
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // New value.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (s1_op)
      csr_pkg::OP_WRITE: wr_data = s1_operand;
      csr_pkg::OP_SET:   wr_data = rdata | s1_operand;
      csr_pkg::OP_CLEAR: wr_data = rdata & ~s1_operand;
      default:           wr_data = rdata;
    endcase
  end

  // Set or clear with a zero field is only a read.
  assign wr_en = s1_valid && (s1_op == csr_pkg::OP_WRITE || !s1_zero_src);
  assign wr_addr = s1_addr;

  // Destination gets the old value.
  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    rd_index <= s1_rd;
    rd_data  <= rdata;
  end

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_regfile (
  input  logic               clk,
  input  logic               rst,
  input  csr_pkg::csr_addr_t rd_addr,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t wr_addr,
  input  csr_pkg::word_t     wr_data,
  input  logic               s1_exc,
  input  csr_pkg::cause_t    s1_cause,
  input  csr_pkg::word_t     s1_epc,
  input  csr_pkg::word_t     s1_tval,
  input  logic               s1_mret,
  input  logic               s1_retire,
  input  csr_pkg::word_t     s1_pc,
  input  logic               meip,
  input  logic               mtip,
  input  logic               msip,
  output csr_pkg::word_t     rdata,
  output logic               trap_valid,
  output csr_pkg::word_t     trap_target,
  output logic               mret_valid,
  output csr_pkg::word_t     mret_target
);
  logic            mstatus_mie, mstatus_mpie;
  logic [1:0]      mstatus_mpp, mstatus_fs;
  logic            mie_meie, mie_mtie, mie_msie;
  logic            mip_meip, mip_mtip, mip_msip;
  csr_pkg::word_t  mtvec, mscratch, mepc, mtval;
  logic            mcause_irq;
  csr_pkg::cause_t mcause_code;
  logic [63:0]     mcycle, minstret;

  logic            pend_ext, pend_tim, pend_sw;
  logic            irq_take, trap_take;
  csr_pkg::cause_t trap_code;
  csr_pkg::word_t  trap_base;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read mux.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rdata = '0;
    case (rd_addr)
      `CSR_MSTATUS: begin
        rdata[`MSTATUS_SD]   = &mstatus_fs; // Dirty summary.
        rdata[`MSTATUS_FS]   = mstatus_fs;
        rdata[`MSTATUS_MPP]  = mstatus_mpp;
        rdata[`MSTATUS_MPIE] = mstatus_mpie;
        rdata[`MSTATUS_MIE]  = mstatus_mie;
      end
      `CSR_MISA:      rdata = `MISA_VALUE;
      `CSR_MIE: begin
        rdata[`IRQ_MEXT]   = mie_meie;
        rdata[`IRQ_MTIMER] = mie_mtie;
        rdata[`IRQ_MSOFT]  = mie_msie;
      end
      `CSR_MIP: begin
        rdata[`IRQ_MEXT]   = mip_meip;
        rdata[`IRQ_MTIMER] = mip_mtip;
        rdata[`IRQ_MSOFT]  = mip_msip;
      end
      `CSR_MTVEC:     rdata = mtvec;
      `CSR_MSCRATCH:  rdata = mscratch;
      `CSR_MEPC:      rdata = mepc;
      `CSR_MCAUSE:    rdata = {mcause_irq, 27'b0, mcause_code};
      `CSR_MTVAL:     rdata = mtval;
      `CSR_MCYCLE:    rdata = mcycle[31:0];
      `CSR_MCYCLEH:   rdata = mcycle[63:32];
      `CSR_MINSTRET:  rdata = minstret[31:0];
      `CSR_MINSTRETH: rdata = minstret[63:32];
      default:        rdata = '0;
    endcase
  end

  // Interrupt selection, external first.
  assign pend_ext  = mip_meip && mie_meie;
  assign pend_tim  = mip_mtip && mie_mtie;
  assign pend_sw   = mip_msip && mie_msie;
  assign irq_take  = !s1_exc && s1_retire && mstatus_mie && (pend_ext || pend_tim || pend_sw);
  assign trap_take = s1_exc || irq_take;
  assign trap_code = s1_exc ? s1_cause :
                     pend_ext ? `IRQ_MEXT :
                     pend_tim ? `IRQ_MTIMER : `IRQ_MSOFT;
  assign trap_base = {mtvec[31:2], 2'b00};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register updates.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus_mie <= 1'b0;
      mstatus_mpie <= 1'b0;
      mstatus_mpp <= '0;
      mstatus_fs <= '0;
      mie_meie <= 1'b0;
      mie_mtie <= 1'b0;
      mie_msie <= 1'b0;
      mip_meip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_msip <= 1'b0;
      mtvec <= '0;
      mscratch <= '0;
      mepc <= '0;
      mtval <= '0;
      mcause_irq <= 1'b0;
      mcause_code <= '0;
      trap_valid <= 1'b0;
      mret_valid <= 1'b0;
    end else begin
      mip_meip <= meip; // Pins land one cycle late.
      mip_mtip <= mtip;
      mip_msip <= msip;
      if (wr_en) begin
        case (wr_addr)
          `CSR_MSTATUS: begin
            mstatus_mie  <= wr_data[`MSTATUS_MIE];
            mstatus_mpie <= wr_data[`MSTATUS_MPIE];
            mstatus_mpp  <= wr_data[`MSTATUS_MPP];
            mstatus_fs   <= wr_data[`MSTATUS_FS];
          end
          `CSR_MIE: begin
            mie_meie <= wr_data[`IRQ_MEXT];
            mie_mtie <= wr_data[`IRQ_MTIMER];
            mie_msie <= wr_data[`IRQ_MSOFT];
          end
          `CSR_MTVEC:    mtvec <= wr_data;
          `CSR_MSCRATCH: mscratch <= wr_data;
          `CSR_MEPC:     mepc <= wr_data;
          `CSR_MTVAL:    mtval <= wr_data;
          `CSR_MCAUSE: begin
            mcause_irq  <= wr_data[31];
            mcause_code <= wr_data[3:0];
          end
          default: ; // mip machine bits follow the pins only.
        endcase
      end
      // Trap entry overrides a CSR write in the same cycle.
      if (trap_take) begin
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;
        mepc         <= s1_exc ? s1_epc : s1_pc;
        mtval        <= s1_exc ? s1_tval : '0;
        mcause_irq   <= !s1_exc;
        mcause_code  <= trap_code;
      end else if (s1_mret) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end
      trap_valid <= trap_take;
      mret_valid <= s1_mret;
    end
  end

  always_ff @(posedge clk) begin
    if (irq_take && mtvec[1:0] == 2'b01) begin
      trap_target <= trap_base + {26'b0, trap_code, 2'b00}; // Vectored.
    end else begin
      trap_target <= trap_base;
    end
    mret_target <= mepc;
  end

  // Counters. A write to either half stands in for the increment.
  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      if (wr_en && wr_addr == `CSR_MCYCLE) begin
        mcycle <= {mcycle[63:32], wr_data};
      end else if (wr_en && wr_addr == `CSR_MCYCLEH) begin
        mcycle <= {wr_data, mcycle[31:0]};
      end else begin
        mcycle <= mcycle + 64'd1;
      end
      if (wr_en && wr_addr == `CSR_MINSTRET) begin
        minstret <= {minstret[63:32], wr_data};
      end else if (wr_en && wr_addr == `CSR_MINSTRETH) begin
        minstret <= {wr_data, minstret[31:0]};
      end else if (s1_retire) begin
        minstret <= minstret + 64'd1;
      end
    end
  end

endmodule

/* design/csr_unit.sv */
`timescale 1ns/10ps

module csr_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               instr_valid,
  input  logic [2:0]         instr_funct3,
  input  csr_pkg::csr_addr_t instr_addr,
  input  csr_pkg::reg_idx_t  instr_rs1,
  input  csr_pkg::word_t     instr_src,
  input  csr_pkg::reg_idx_t  instr_rd,
  input  csr_pkg::word_t     instr_pc,
  input  logic               exc_valid,
  input  csr_pkg::cause_t    exc_cause,
  input  csr_pkg::word_t     exc_pc,
  input  csr_pkg::word_t     exc_tval,
  input  logic               mret,
  input  logic               retire,
  input  logic               meip,
  input  logic               mtip,
  input  logic               msip,
  output logic               rd_valid,
  output csr_pkg::reg_idx_t  rd_index,
  output csr_pkg::word_t     rd_data,
  output logic               trap_valid,
  output csr_pkg::word_t     trap_target,
  output logic               mret_valid,
  output csr_pkg::word_t     mret_target
);
  // Stage one to stage two.
  logic               s1_valid, s1_exc, s1_mret, s1_retire, s1_zero_src;
  csr_pkg::csr_op_e   s1_op;
  csr_pkg::csr_addr_t s1_addr;
  csr_pkg::word_t     s1_operand, s1_pc, s1_epc, s1_tval;
  csr_pkg::reg_idx_t  s1_rd;
  csr_pkg::cause_t    s1_cause;

  // Read and write between regfile and modify.
  csr_pkg::word_t     rdata, wr_data;
  csr_pkg::csr_addr_t wr_addr;
  logic               wr_en;

  csr_decode u_decode (
    .clk, .rst, .instr_valid, .instr_funct3, .instr_addr, .instr_rs1, .instr_src,
    .instr_rd, .instr_pc, .exc_valid, .exc_cause, .exc_pc, .exc_tval, .mret, .retire,
    .s1_valid, .s1_op, .s1_addr, .s1_operand, .s1_rd, .s1_pc, .s1_exc, .s1_cause,
    .s1_epc, .s1_tval, .s1_mret, .s1_retire, .s1_zero_src
  );

  csr_regfile u_regfile (
    .clk, .rst, .rd_addr(s1_addr), .wr_en, .wr_addr, .wr_data, .s1_exc, .s1_cause,
    .s1_epc, .s1_tval, .s1_mret, .s1_retire, .s1_pc, .meip, .mtip, .msip, .rdata,
    .trap_valid, .trap_target, .mret_valid, .mret_target
  );

  csr_modify u_modify (
    .clk, .rst, .s1_valid, .s1_op, .s1_addr, .s1_operand, .s1_rd, .s1_zero_src,
    .rdata, .wr_en, .wr_addr, .wr_data, .rd_valid, .rd_index, .rd_data
  );

endmodule

/* test/csr_unit_tb.sv */
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_tb;
  localparam int N_RAND      = 32;
  localparam int STIM_CYCLES = 10 + N_RAND + 120;

  logic               clk, rst;
  logic               instr_valid, exc_valid, mret, retire, meip, mtip, msip;
  logic [2:0]         instr_funct3;
  csr_pkg::csr_addr_t instr_addr;
  csr_pkg::reg_idx_t  instr_rs1, instr_rd, rd_index;
  csr_pkg::word_t     instr_src, instr_pc, exc_pc, exc_tval;
  csr_pkg::cause_t    exc_cause;
  logic               rd_valid, trap_valid, mret_valid;
  csr_pkg::word_t     rd_data, trap_target, mret_target;

  // Expected outputs set with the stimulus, then delayed two cycles.
  logic               e_rd, e_chk, e_trap, e_mret;
  csr_pkg::reg_idx_t  e_idx;
  csr_pkg::word_t     e_data, e_tgt, e_ret;
  logic               e_rd_p[2], e_chk_p[2], e_trap_p[2], e_mret_p[2];
  csr_pkg::reg_idx_t  e_idx_p[2];
  csr_pkg::word_t     e_data_p[2], e_tgt_p[2], e_ret_p[2];

  csr_pkg::word_t     m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  logic [31:0]        lfsr;
  csr_pkg::word_t     got_q[$];
  int                 rd_count = 0;

  csr_unit u_dut (
    .clk, .rst, .instr_valid, .instr_funct3, .instr_addr, .instr_rs1, .instr_src,
    .instr_rd, .instr_pc, .exc_valid, .exc_cause, .exc_pc, .exc_tval, .mret, .retire,
    .meip, .mtip, .msip, .rd_valid, .rd_index, .rd_data, .trap_valid, .trap_target,
    .mret_valid, .mret_target
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #((STIM_CYCLES + 100) * 20);
    $display("Watchdog expired before the tests finished.");
    $display("*** FAILED ***");
    $fatal(1);
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s got %h expected %h", name, got, exp);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0); // Galois step.
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic is_known(input csr_pkg::csr_addr_t addr);
    return addr inside {`CSR_MSTATUS, `CSR_MISA, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
                        `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP, `CSR_MCYCLE,
                        `CSR_MCYCLEH, `CSR_MINSTRET, `CSR_MINSTRETH};
  endfunction

  function automatic csr_pkg::word_t model_read(input csr_pkg::csr_addr_t addr);
    case (addr)
      `CSR_MSTATUS:  return {&m_mstatus[`MSTATUS_FS], m_mstatus[30:0]};
      `CSR_MISA:     return `MISA_VALUE;
      `CSR_MIE:      return m_mie;
      `CSR_MTVEC:    return m_mtvec;
      `CSR_MSCRATCH: return m_mscratch;
      `CSR_MEPC:     return m_mepc;
      `CSR_MCAUSE:   return m_mcause;
      `CSR_MTVAL:    return m_mtval;
      default:       return '0;
    endcase
  endfunction

  task automatic model_write(input csr_pkg::csr_addr_t addr, input csr_pkg::word_t v);
    case (addr)
      `CSR_MSTATUS:  m_mstatus  = v & 32'h0000_7888; // MIE, MPIE, MPP, FS.
      `CSR_MIE:      m_mie      = v & 32'h0000_0888;
      `CSR_MTVEC:    m_mtvec    = v;
      `CSR_MSCRATCH: m_mscratch = v;
      `CSR_MEPC:     m_mepc     = v;
      `CSR_MCAUSE:   m_mcause   = v & 32'h8000_000F;
      `CSR_MTVAL:    m_mtval    = v;
      default: ;
    endcase
  endtask

  function automatic csr_pkg::word_t model_trap(input csr_pkg::cause_t cause,
      input csr_pkg::word_t epc, input csr_pkg::word_t tval, input logic irq);
    m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
    m_mstatus[`MSTATUS_MIE]  = 1'b0;
    m_mepc   = epc;
    m_mtval  = tval;
    m_mcause = {irq, 27'b0, cause};
    return {m_mtvec[31:2], 2'b00} +
           ((irq && m_mtvec[1:0] == 2'b01) ? 32'(cause) * 32'd4 : 32'd0);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus tasks, all on the falling edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic clear_inputs();
    instr_valid = 1'b0;
    exc_valid   = 1'b0;
    mret        = 1'b0;
    retire      = 1'b0;
    e_rd        = 1'b0;
    e_chk       = 1'b0;
    e_trap      = 1'b0;
    e_mret      = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_inputs();
    end
  endtask

  task automatic csr_instr(input logic [2:0] f3, input csr_pkg::csr_addr_t addr,
                           input csr_pkg::reg_idx_t rs1, input csr_pkg::word_t src);
    csr_pkg::word_t opnd, old, pc;
    logic           wr, bad;
    opnd = f3[2] ? {27'b0, rs1} : src;
    wr   = (f3[1:0] == 2'b01) || (rs1 != '0); // Set or clear with zero only reads.
    bad  = !is_known(addr) || (addr == `CSR_MISA && wr);
    old  = model_read(addr);
    pc   = rand_bits(32) & ~32'h3;
    @(negedge clk);
    clear_inputs();
    instr_valid  = 1'b1;
    instr_funct3 = f3;
    instr_addr   = addr;
    instr_rs1    = rs1;
    instr_src    = src;
    instr_rd     = 5'(rand_bits(5));
    instr_pc     = pc;
    if (bad) begin
      e_trap = 1'b1;
      e_tgt  = model_trap(`CAUSE_ILLEGAL_INSTR, pc, '0, 1'b0);
    end else begin
      e_rd   = 1'b1;
      e_chk  = !(addr inside {`CSR_MIP, `CSR_MCYCLE, `CSR_MCYCLEH, `CSR_MINSTRET,
                              `CSR_MINSTRETH});
      e_idx  = instr_rd;
      e_data = old;
      if (wr) begin
        model_write(addr, (f3[1:0] == 2'b01) ? opnd :
                          (f3[1:0] == 2'b10) ? (old | opnd) : (old & ~opnd));
      end
    end
  endtask

  task automatic raise_exc(input csr_pkg::cause_t cause, input csr_pkg::word_t pc,
                           input csr_pkg::word_t tval);
    @(negedge clk);
    clear_inputs();
    exc_valid = 1'b1;
    exc_cause = cause;
    exc_pc    = pc;
    exc_tval  = tval;
    e_trap    = 1'b1;
    e_tgt     = model_trap(cause, pc, tval, 1'b0);
  endtask

  task automatic do_mret();
    @(negedge clk);
    clear_inputs();
    mret   = 1'b1;
    e_mret = 1'b1;
    e_ret  = m_mepc;
    m_mstatus[`MSTATUS_MIE]  = m_mstatus[`MSTATUS_MPIE];
    m_mstatus[`MSTATUS_MPIE] = 1'b1;
  endtask

  task automatic retire_one(input csr_pkg::word_t pc);
    logic [2:0] pend;
    @(negedge clk);
    clear_inputs();
    retire   = 1'b1;
    instr_pc = pc;
    pend = {meip & m_mie[`IRQ_MEXT], mtip & m_mie[`IRQ_MTIMER], msip & m_mie[`IRQ_MSOFT]};
    if (m_mstatus[`MSTATUS_MIE] && pend != 3'b000) begin
      e_trap = 1'b1;
      e_tgt  = model_trap(pend[2] ? `IRQ_MEXT : pend[1] ? `IRQ_MTIMER : `IRQ_MSOFT,
                          pc, '0, 1'b1);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output checks, two cycles after the input.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assert property (@(posedge clk) disable iff (!rst)
                   rd_valid == e_rd_p[1])
    else report_mismatch("rd_valid", 32'($sampled(rd_valid)), 32'($sampled(e_rd_p[1])));
  assert property (@(posedge clk) disable iff (!rst)
                   !rd_valid || rd_index == e_idx_p[1])
    else report_mismatch("rd_index", 32'($sampled(rd_index)), 32'($sampled(e_idx_p[1])));
  assert property (@(posedge clk) disable iff (!rst)
                   !rd_valid || !e_chk_p[1] || rd_data == e_data_p[1])
    else report_mismatch("rd_data", $sampled(rd_data), $sampled(e_data_p[1]));
  assert property (@(posedge clk) disable iff (!rst)
                   trap_valid == e_trap_p[1])
    else report_mismatch("trap_valid", 32'($sampled(trap_valid)),
                         32'($sampled(e_trap_p[1])));
  assert property (@(posedge clk) disable iff (!rst)
                   !trap_valid || trap_target == e_tgt_p[1])
    else report_mismatch("trap_target", $sampled(trap_target), $sampled(e_tgt_p[1]));
  assert property (@(posedge clk) disable iff (!rst)
                   mret_valid == e_mret_p[1])
    else report_mismatch("mret_valid", 32'($sampled(mret_valid)),
                         32'($sampled(e_mret_p[1])));
  assert property (@(posedge clk) disable iff (!rst)
                   !mret_valid || mret_target == e_ret_p[1])
    else report_mismatch("mret_target", $sampled(mret_target), $sampled(e_ret_p[1]));

  always @(posedge clk) begin
    if (rst && rd_valid) begin
      got_q.push_back(rd_data);
      rd_count <= rd_count + 1;
    end
    e_rd_p[0]   <= e_rd;
    e_rd_p[1]   <= e_rd_p[0];
    e_chk_p[0]  <= e_chk;
    e_chk_p[1]  <= e_chk_p[0];
    e_idx_p[0]  <= e_idx;
    e_idx_p[1]  <= e_idx_p[0];
    e_data_p[0] <= e_data;
    e_data_p[1] <= e_data_p[0];
    e_trap_p[0] <= e_trap;
    e_trap_p[1] <= e_trap_p[0];
    e_tgt_p[0]  <= e_tgt;
    e_tgt_p[1]  <= e_tgt_p[0];
    e_mret_p[0] <= e_mret;
    e_mret_p[1] <= e_mret_p[0];
    e_ret_p[0]  <= e_ret;
    e_ret_p[1]  <= e_ret_p[0];
  end

  initial begin
    logic [2:0]         f3;
    csr_pkg::csr_addr_t addr;
    int                 n0, n_ret, k;
    rst  = 1'b0;
    lfsr = 32'hb92d_a63f;
    {meip, mtip, msip} = 3'b000;
    instr_funct3 = '0;
    instr_addr   = '0;
    instr_rs1    = '0;
    instr_src    = '0;
    instr_rd     = '0;
    instr_pc     = '0;
    exc_cause    = '0;
    exc_pc       = '0;
    exc_tval     = '0;
    {e_idx, e_data, e_tgt, e_ret} = '0;
    {m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
    clear_inputs();
    repeat (10) @(negedge clk);
    rst = 1'b1;

    // Reset values.
    csr_instr(`F3_CSRRS, `CSR_MSTATUS, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MTVEC, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MSCRATCH, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MISA, 5'd0, '0);

    for (int i = 0; i < N_RAND; i++) begin
      f3 = 3'(rand_bits(3));
      if (f3[1:0] == 2'b00) f3[1:0] = 2'b11; // No CSR op there.
      addr = (rand_bits(1) != 0) ? `CSR_MTVEC : `CSR_MSCRATCH;
      csr_instr(f3, addr, 5'(rand_bits(5)), rand_bits(32));
    end
    csr_instr(`F3_CSRRS, `CSR_MTVEC, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MSCRATCH, 5'd0, '0);

    // Illegal accesses.
    csr_instr(`F3_CSRRSI, `CSR_MSTATUS, 5'd8, '0);
    csr_instr(`F3_CSRRW, 12'h7C0, 5'(rand_bits(5)), rand_bits(32));
    csr_instr(`F3_CSRRS, `CSR_MCAUSE, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MEPC, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MSTATUS, 5'd0, '0);
    csr_instr(`F3_CSRRW, `CSR_MISA, 5'd1, rand_bits(32));
    csr_instr(`F3_CSRRS, `CSR_MISA, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MEPC, 5'd0, '0);

    // Exception and return.
    csr_instr(`F3_CSRRSI, `CSR_MSTATUS, 5'd8, '0);
    raise_exc(4'(rand_bits(4)), rand_bits(32), rand_bits(32));
    csr_instr(`F3_CSRRS, `CSR_MEPC, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MTVAL, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MCAUSE, 5'd0, '0);
    do_mret();
    csr_instr(`F3_CSRRS, `CSR_MSTATUS, 5'd0, '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vectored interrupts.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    csr_instr(`F3_CSRRW, `CSR_MTVEC, 5'd1, (rand_bits(32) & ~32'h3) | 32'h1);
    csr_instr(`F3_CSRRW, `CSR_MIE, 5'd1, 32'h0000_0888);
    csr_instr(`F3_CSRRSI, `CSR_MSTATUS, 5'd8, '0);
    mtip = 1'b1;
    msip = 1'b1;
    idle(2); // Pins reach mip a cycle late.
    retire_one(rand_bits(32) & ~32'h3);
    csr_instr(`F3_CSRRS, `CSR_MCAUSE, 5'd0, '0);
    csr_instr(`F3_CSRRS, `CSR_MEPC, 5'd0, '0);
    csr_instr(`F3_CSRRSI, `CSR_MSTATUS, 5'd8, '0);
    meip = 1'b1;
    idle(2);
    retire_one(rand_bits(32) & ~32'h3);
    csr_instr(`F3_CSRRS, `CSR_MCAUSE, 5'd0, '0);
    {meip, mtip, msip} = 3'b000;
    idle(3);

    // Counters.
    n0 = rd_count;
    csr_instr(`F3_CSRRS, `CSR_MINSTRET, 5'd0, '0);
    n_ret = 1 + rand_bits(3);
    for (int i = 0; i < n_ret; i++) begin
      retire_one(rand_bits(32) & ~32'h3);
      if (rand_bits(1) != 0) idle(1);
    end
    csr_instr(`F3_CSRRS, `CSR_MINSTRET, 5'd0, '0);
    while (rd_count < n0 + 2) @(negedge clk);
    assert (got_q[n0 + 1] - got_q[n0] == 32'(n_ret))
      else report_mismatch("minstret delta", got_q[n0 + 1] - got_q[n0], 32'(n_ret));

    idle(3);
    n0 = rd_count;
    k  = 2 + rand_bits(3);
    csr_instr(`F3_CSRRS, `CSR_MCYCLE, 5'd0, '0);
    idle(k - 1);
    csr_instr(`F3_CSRRS, `CSR_MCYCLE, 5'd0, '0);
    while (rd_count < n0 + 2) @(negedge clk);
    assert (got_q[n0 + 1] - got_q[n0] == 32'(k))
      else report_mismatch("mcycle delta", got_q[n0 + 1] - got_q[n0], 32'(k));

    idle(4);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* list.f */
+incdir+design
design/csr_pkg.sv
design/csr_decode.sv
design/csr_modify.sv
design/csr_regfile.sv
design/csr_unit.sv
test/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module csr_unit_tb -f list.f -o csr_sim

out=$(./obj_dir/csr_sim) || { echo "$out"; exit 1; }
echo "$out"
if echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$'; then
  exit 0
else
  exit 1
fi
